// ==== common/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// log2 of line counts per level
`define L1_LG_LINES 4
// must not be smaller than L1_LG_LINES
`define L2_LG_LINES 5

`endif

// ==== common/cache_line_pkg.sv ====
package cache_line_pkg;

   // line state for levels that can hold modified data (l1d, l2)
   // valid sits in the msb, dirty in the lsb
   typedef struct packed
   {
      logic valid;
      logic dirty;
   } dirty_line_t;

   // instruction side never holds modified data
   typedef struct packed
   {
      logic valid;
   } clean_line_t;

endpackage

// ==== common/flush_ctl_pkg.sv ====
package flush_ctl_pkg;

   typedef enum logic [2:0]
   {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2, // l1d done, waiting on l1i
      GOT_L1I          = 3'd3, // l1i done, waiting on l1d
      FLUSH_L2         = 3'd4
   } flush_state_t;

   // selects a cache level for touch and probe
   typedef enum logic [1:0]
   {
      SEL_L1D = 2'd0,
      SEL_L1I = 2'd1,
      SEL_L2  = 2'd2
   } cache_sel_t;

endpackage

// ==== common/sweep_if.sv ====
`timescale 1ns/1ps

interface sweep_if #(parameter int LG_LINES = 4);

   logic                start;    // one cycle, from sequencer
   logic                complete; // one cycle, from cache level
   logic                wb_valid;
   logic [LG_LINES-1:0] wb_index;

   modport sequencer
   (
      output start,
      input  complete
   );

   modport cache
   (
      input  start,
      output complete,
      output wb_valid,
      output wb_index
   );

   // consumer of the writeback stream
   modport sink
   (
      input wb_valid,
      input wb_index
   );

endinterface

// ==== src/flush_sequencer.sv ====
`timescale 1ns/1ps

module flush_sequencer
(
   input  logic clk,
   input  logic reset,
   input  logic flush_l1d_req,
   input  logic flush_l1i_req,
   sweep_if.sequencer l1d,
   sweep_if.sequencer l1i,
   sweep_if.sequencer l2,
   output logic in_flush_mode,
   output logic flush_done
);

   flush_ctl_pkg::flush_state_t r_state, n_state;
   logic r_flush, n_flush;
   logic r_start_l1d, n_start_l1d;
   logic r_start_l1i, n_start_l1i;
   logic r_start_l2, n_start_l2;
   logic r_done, n_done;

   assign in_flush_mode = r_flush;
   assign flush_done = r_done;
   assign l1d.start = r_start_l1d;
   assign l1i.start = r_start_l1i;
   assign l2.start = r_start_l2;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= flush_ctl_pkg::FLUSH_IDLE;
         r_flush <= 1'b0;
         r_start_l1d <= 1'b0;
         r_start_l1i <= 1'b0;
         r_start_l2 <= 1'b0;
         r_done <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
         r_start_l1d <= n_start_l1d;
         r_start_l1i <= n_start_l1i;
         r_start_l2 <= n_start_l2;
         r_done <= n_done;
      end
   end

   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      n_start_l1d = 1'b0;
      n_start_l1i = 1'b0;
      n_start_l2 = 1'b0;
      n_done = 1'b0;

      case (r_state)
         flush_ctl_pkg::FLUSH_IDLE:
         begin
            n_start_l1d = flush_l1d_req;
            n_start_l1i = flush_l1i_req;
            if (flush_l1d_req || flush_l1i_req)
            begin
               n_flush = 1'b1;
            end
            // an unrequested level counts as already flushed
            if (flush_l1d_req && flush_l1i_req)
               n_state = flush_ctl_pkg::WAIT_FOR_L1D_L1I;
            else if (flush_l1i_req)
               n_state = flush_ctl_pkg::GOT_L1D;
            else if (flush_l1d_req)
               n_state = flush_ctl_pkg::GOT_L1I;
         end
         flush_ctl_pkg::WAIT_FOR_L1D_L1I:
         begin
            if (l1d.complete && l1i.complete)
            begin
               n_state = flush_ctl_pkg::FLUSH_L2;
               n_start_l2 = 1'b1;
            end
            else if (l1d.complete)
               n_state = flush_ctl_pkg::GOT_L1D;
            else if (l1i.complete)
               n_state = flush_ctl_pkg::GOT_L1I;
         end
         flush_ctl_pkg::GOT_L1D:
         begin
            if (l1i.complete)
            begin
               n_state = flush_ctl_pkg::FLUSH_L2;
               n_start_l2 = 1'b1;
            end
         end
         flush_ctl_pkg::GOT_L1I:
         begin
            if (l1d.complete)
            begin
               n_state = flush_ctl_pkg::FLUSH_L2;
               n_start_l2 = 1'b1;
            end
         end
         flush_ctl_pkg::FLUSH_L2:
         begin
            if (l2.complete)
            begin
               n_state = flush_ctl_pkg::FLUSH_IDLE;
               n_flush = 1'b0;
               n_done = 1'b1;
            end
         end
         default:
         begin
            n_state = flush_ctl_pkg::FLUSH_IDLE;
            n_flush = 1'b0;
         end
      endcase
   end

endmodule

// ==== src/line_sweep_counter.sv ====
`timescale 1ns/1ps

module line_sweep_counter #(parameter int LG_LINES = 4)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   output logic                active,
   output logic [LG_LINES-1:0] index,
   output logic                last
);

   logic                r_active;
   logic [LG_LINES-1:0] r_index;

   assign active = r_active;
   assign index = r_index;
   assign last = r_active && (r_index == {LG_LINES{1'b1}}); // final line of the sweep

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_active <= 1'b0;
         r_index <= '0;
      end
      else if (start)
      begin
         r_active <= 1'b1;
         r_index <= '0;
      end
      else if (r_active)
      begin
         r_index <= r_index + 1'b1; // wraps back to zero after last
         if (last)
         begin
            r_active <= 1'b0;
         end
      end
   end

endmodule

// ==== cache/line_state_array.sv ====
`timescale 1ns/1ps

module line_state_array #(
   parameter type entry_t = logic,
   parameter int  LG_LINES = 4
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                fill_valid,
   input  logic [LG_LINES-1:0] fill_index,
   input  entry_t              fill_entry,
   input  logic                clear_valid,
   input  logic [LG_LINES-1:0] clear_index,
   input  logic [LG_LINES-1:0] read_index,
   output entry_t              read_entry,
   input  logic [LG_LINES-1:0] probe_index,
   output entry_t              probe_entry
);

   localparam int LINES = 1 << LG_LINES;

   entry_t entries [LINES];
   entry_t r_probe;

   assign read_entry = entries[read_index];
   assign probe_entry = r_probe;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < LINES; i++)
         begin
            entries[i] <= '0;
         end
         r_probe <= '0;
      end
      else
      begin
         if (fill_valid)
         begin
            entries[fill_index] <= fill_entry;
         end
         // later write wins, so clear beats a fill to the same line
         if (clear_valid)
         begin
            entries[clear_index] <= '0;
         end
         r_probe <= entries[probe_index]; // state before this edge's writes
      end
   end

endmodule

// ==== cache/cache_flush_unit.sv ====
`timescale 1ns/1ps

module cache_flush_unit #(
   parameter type entry_t = logic,
   parameter int  LG_LINES = 4
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                fill_valid,
   input  logic [LG_LINES-1:0] fill_index,
   input  logic                fill_dirty,
   input  logic [LG_LINES-1:0] probe_index,
   output logic                probe_hit,
   sweep_if.cache              sweep
);

   localparam int ENTRY_W = $bits(entry_t);
   // a single-bit entry only tracks valid
   localparam bit HAS_DIRTY = (ENTRY_W > 1);

   logic [ENTRY_W-1:0] fill_bits;
   logic [ENTRY_W-1:0] read_bits;
   logic [ENTRY_W-1:0] probe_bits;
   entry_t             fill_entry;
   entry_t             read_entry;
   entry_t             probe_entry;
   logic                sweep_active;
   logic [LG_LINES-1:0] sweep_index;
   logic                sweep_last;
   logic                line_valid;
   logic                line_dirty;
   logic                r_complete;

   always_comb
   begin
      fill_bits = '0;
      fill_bits[ENTRY_W-1] = 1'b1; // valid in msb
      if (HAS_DIRTY)
      begin
         fill_bits[0] = fill_dirty;
      end
   end

   assign fill_entry = entry_t'(fill_bits);
   assign read_bits = read_entry;
   assign probe_bits = probe_entry;

   assign line_valid = read_bits[ENTRY_W-1];
   assign line_dirty = HAS_DIRTY ? read_bits[0] : 1'b0;
   assign probe_hit = probe_bits[ENTRY_W-1];

   line_state_array #(.entry_t(entry_t), .LG_LINES(LG_LINES)) state_array
   (
      .clk(clk),
      .reset(reset),
      .fill_valid(fill_valid),
      .fill_index(fill_index),
      .fill_entry(fill_entry),
      .clear_valid(sweep_active), // every swept line ends invalid
      .clear_index(sweep_index),
      .read_index(sweep_index),
      .read_entry(read_entry),
      .probe_index(probe_index),
      .probe_entry(probe_entry)
   );

   line_sweep_counter #(.LG_LINES(LG_LINES)) sweep_counter
   (
      .clk(clk),
      .reset(reset),
      .start(sweep.start),
      .active(sweep_active),
      .index(sweep_index),
      .last(sweep_last)
   );

   always_ff @(posedge clk)
   begin
      if (reset)
         r_complete <= 1'b0;
      else
         r_complete <= sweep_last;
   end

   assign sweep.complete = r_complete;
   assign sweep.wb_valid = sweep_active && line_valid && line_dirty;
   assign sweep.wb_index = sweep_index;

endmodule

// ==== src/cache_flush_top.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_flush_top
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      touch_valid,
   input  flush_ctl_pkg::cache_sel_t touch_sel,
   input  logic [`L2_LG_LINES-1:0]   touch_index,
   input  logic                      touch_dirty,
   input  logic                      flush_l1d_req,
   input  logic                      flush_l1i_req,
   input  flush_ctl_pkg::cache_sel_t probe_sel,
   input  logic [`L2_LG_LINES-1:0]   probe_index,
   output logic                      probe_hit,
   output logic                      in_flush_mode,
   output logic                      flush_done,
   output logic                      mem_wb_valid,
   output logic [`L2_LG_LINES-1:0]   mem_wb_index
);

   logic                    l1d_fill_valid;
   logic                    l1i_fill_valid;
   logic                    l2_fill_valid;
   logic [`L2_LG_LINES-1:0] l2_fill_index;
   logic                    l2_fill_dirty;
   logic                    l1d_probe_hit;
   logic                    l1i_probe_hit;
   logic                    l2_probe_hit;

   sweep_if #(.LG_LINES(`L1_LG_LINES)) l1d_sweep();
   sweep_if #(.LG_LINES(`L1_LG_LINES)) l1i_sweep();
   sweep_if #(.LG_LINES(`L2_LG_LINES)) l2_sweep();

   // touch decode
   assign l1d_fill_valid = touch_valid && (touch_sel == flush_ctl_pkg::SEL_L1D);
   assign l1i_fill_valid = touch_valid && (touch_sel == flush_ctl_pkg::SEL_L1I);

   // l1d writebacks land in l2 as dirty lines
   assign l2_fill_valid = l1d_sweep.wb_valid ||
                          (touch_valid && (touch_sel == flush_ctl_pkg::SEL_L2));
   assign l2_fill_index = l1d_sweep.wb_valid ? `L2_LG_LINES'(l1d_sweep.wb_index) :
                          touch_index;
   assign l2_fill_dirty = l1d_sweep.wb_valid || touch_dirty;

   assign probe_hit = (probe_sel == flush_ctl_pkg::SEL_L1D) ? l1d_probe_hit :
                      (probe_sel == flush_ctl_pkg::SEL_L1I) ? l1i_probe_hit :
                      l2_probe_hit;

   assign mem_wb_valid = l2_sweep.wb_valid;
   assign mem_wb_index = l2_sweep.wb_index;

   flush_sequencer sequencer
   (
      .clk(clk),
      .reset(reset),
      .flush_l1d_req(flush_l1d_req),
      .flush_l1i_req(flush_l1i_req),
      .l1d(l1d_sweep.sequencer),
      .l1i(l1i_sweep.sequencer),
      .l2(l2_sweep.sequencer),
      .in_flush_mode(in_flush_mode),
      .flush_done(flush_done)
   );

   cache_flush_unit #(
      .entry_t(cache_line_pkg::dirty_line_t),
      .LG_LINES(`L1_LG_LINES)
   ) l1d_unit
   (
      .clk(clk),
      .reset(reset),
      .fill_valid(l1d_fill_valid),
      .fill_index(touch_index[`L1_LG_LINES-1:0]),
      .fill_dirty(touch_dirty),
      .probe_index(probe_index[`L1_LG_LINES-1:0]),
      .probe_hit(l1d_probe_hit),
      .sweep(l1d_sweep.cache)
   );

   // never writes back, dirty input has no effect
   cache_flush_unit #(
      .entry_t(cache_line_pkg::clean_line_t),
      .LG_LINES(`L1_LG_LINES)
   ) l1i_unit
   (
      .clk(clk),
      .reset(reset),
      .fill_valid(l1i_fill_valid),
      .fill_index(touch_index[`L1_LG_LINES-1:0]),
      .fill_dirty(touch_dirty),
      .probe_index(probe_index[`L1_LG_LINES-1:0]),
      .probe_hit(l1i_probe_hit),
      .sweep(l1i_sweep.cache)
   );

   cache_flush_unit #(
      .entry_t(cache_line_pkg::dirty_line_t),
      .LG_LINES(`L2_LG_LINES)
   ) l2_unit
   (
      .clk(clk),
      .reset(reset),
      .fill_valid(l2_fill_valid),
      .fill_index(l2_fill_index),
      .fill_dirty(l2_fill_dirty),
      .probe_index(probe_index),
      .probe_hit(l2_probe_hit),
      .sweep(l2_sweep.cache)
   );

endmodule

// ==== verification/cache_flush_assertions.sv ====
`timescale 1ns/1ps

module cache_flush_assertions
(
   input logic                        clk,
   input logic                        reset,
   input flush_ctl_pkg::flush_state_t state,
   input logic                        in_flush_mode,
   input logic                        touch_valid,
   input logic                        l1d_start,
   input logic                        l1i_start,
   input logic                        l2_start,
   input logic                        l1d_complete,
   input logic                        l1i_complete
);

   int   failures = 0;
   logic l1d_pending;
   logic l1i_pending;

   // l1 sweeps started and not yet complete
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         l1d_pending <= 1'b0;
         l1i_pending <= 1'b0;
      end
      else
      begin
         if (l1d_start)
            l1d_pending <= 1'b1;
         else if (l1d_complete)
            l1d_pending <= 1'b0;
         if (l1i_start)
            l1i_pending <= 1'b1;
         else if (l1i_complete)
            l1i_pending <= 1'b0;
      end
   end

   flush_mode_held: assert property (@(posedge clk) disable iff (reset)
      state != flush_ctl_pkg::FLUSH_IDLE |-> in_flush_mode)
   else
   begin
      $error("in_flush_mode low while sequencer is busy");
      failures++;
   end

   start_one_cycle: assert property (@(posedge clk) disable iff (reset)
      (l1d_start || l1i_start || l2_start) |=> !(l1d_start || l1i_start || l2_start))
   else
   begin
      $error("sweep start held longer than one cycle");
      failures++;
   end

   no_touch_in_flush: assert property (@(posedge clk) disable iff (reset)
      in_flush_mode |-> !touch_valid)
   else
   begin
      $error("line touched during a flush");
      failures++;
   end

   // l2 goes only once every awaited l1 sweep has reported
   l2_after_l1: assert property (@(posedge clk) disable iff (reset)
      l2_start |-> !l1d_pending && !l1i_pending && $past(l1d_complete || l1i_complete))
   else
   begin
      $error("l2 sweep started before the l1 sweeps completed");
      failures++;
   end

endmodule

// ==== verification/cache_flush_tb.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_flush_tb;

   localparam int L1_LINES = 1 << `L1_LG_LINES;
   localparam int L2_LINES = 1 << `L2_LG_LINES;
   // 25 flushes and the reset check, each with a full probe pass, plus random touches and margin
   localparam int MAX_CYCLES = 26 * (60 + 2 * L1_LINES + L2_LINES) + 20 * 12 + 600;

   typedef int index_list_t[$];

   logic                      clk = 1'b0;
   logic                      reset;
   logic                      touch_valid;
   flush_ctl_pkg::cache_sel_t touch_sel;
   logic [`L2_LG_LINES-1:0]   touch_index;
   logic                      touch_dirty;
   logic                      flush_l1d_req;
   logic                      flush_l1i_req;
   flush_ctl_pkg::cache_sel_t probe_sel;
   logic [`L2_LG_LINES-1:0]   probe_index;
   logic                      probe_hit;
   logic                      in_flush_mode;
   logic                      flush_done;
   logic                      mem_wb_valid;
   logic [`L2_LG_LINES-1:0]   mem_wb_index;

   // reference line state
   bit l1d_valid [L1_LINES];
   bit l1d_dirty [L1_LINES];
   bit l1i_valid [L1_LINES];
   bit l2_valid [L2_LINES];
   bit l2_dirty [L2_LINES];

   int expected_wb[$];
   int done_count = 0;
   int cycle_count = 0;
   int next_index;

   always #10 clk = ~clk;

   cache_flush_top DUT
   (
      .clk(clk),
      .reset(reset),
      .touch_valid(touch_valid),
      .touch_sel(touch_sel),
      .touch_index(touch_index),
      .touch_dirty(touch_dirty),
      .flush_l1d_req(flush_l1d_req),
      .flush_l1i_req(flush_l1i_req),
      .probe_sel(probe_sel),
      .probe_index(probe_index),
      .probe_hit(probe_hit),
      .in_flush_mode(in_flush_mode),
      .flush_done(flush_done),
      .mem_wb_valid(mem_wb_valid),
      .mem_wb_index(mem_wb_index)
   );

   bind cache_flush_top cache_flush_assertions flush_checks
   (
      .clk(clk),
      .reset(reset),
      .state(sequencer.r_state),
      .in_flush_mode(in_flush_mode),
      .touch_valid(touch_valid),
      .l1d_start(l1d_sweep.start),
      .l1i_start(l1i_sweep.start),
      .l2_start(l2_sweep.start),
      .l1d_complete(l1d_sweep.complete),
      .l1i_complete(l1i_sweep.complete)
   );

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // ascending union of dirty l2 lines and dirty l1d lines mapped into l2
   function automatic index_list_t expected_writebacks(input bit with_l1d);
      index_list_t list;
      for (int i = 0; i < L2_LINES; i++)
      begin
         if (l2_valid[i] && l2_dirty[i])
            list.push_back(i);
         else if (with_l1d && i < L1_LINES && l1d_valid[i] && l1d_dirty[i])
            list.push_back(i);
      end
      return list;
   endfunction

   task automatic touch_line(input flush_ctl_pkg::cache_sel_t sel, input int idx,
                             input bit dirty);
      touch_valid = 1'b1;
      touch_sel = sel;
      touch_index = `L2_LG_LINES'(idx);
      touch_dirty = dirty;
      next_cycle();
      touch_valid = 1'b0;
      case (sel)
         flush_ctl_pkg::SEL_L1D:
         begin
            l1d_valid[idx % L1_LINES] = 1'b1;
            l1d_dirty[idx % L1_LINES] = dirty;
         end
         flush_ctl_pkg::SEL_L1I:
            l1i_valid[idx % L1_LINES] = 1'b1; // dirty ignored
         default:
         begin
            l2_valid[idx] = 1'b1;
            l2_dirty[idx] = dirty;
         end
      endcase
   endtask

   task automatic check_all_lines();
      bit expected;
      int lines;
      for (int lvl = 0; lvl < 3; lvl++)
      begin
         lines = (lvl == 2) ? L2_LINES : L1_LINES;
         for (int i = 0; i < lines; i++)
         begin
            probe_sel = flush_ctl_pkg::cache_sel_t'(lvl);
            probe_index = `L2_LG_LINES'(i);
            next_cycle(); // hit is registered
            if (lvl == 0)
               expected = l1d_valid[i];
            else if (lvl == 1)
               expected = l1i_valid[i];
            else
               expected = l2_valid[i];
            assert (probe_hit === expected)
            else fail_run($sformatf(
               "mismatch at %0t: probe_hit level %0d line %0d expected %0b, got %0b",
               $time, lvl, i, expected, probe_hit));
         end
      end
   endtask

   // late_l1i raises an l1i request one cycle into the flush, which must be ignored
   task automatic run_flush(input bit req_l1d, input bit req_l1i, input bit late_l1i);
      int done_before;
      done_before = done_count;
      expected_wb = expected_writebacks(req_l1d);
      flush_l1d_req = req_l1d;
      flush_l1i_req = req_l1i;
      next_cycle();
      flush_l1d_req = 1'b0;
      flush_l1i_req = late_l1i;
      assert (in_flush_mode === 1'b1)
      else fail_run($sformatf("mismatch at %0t: in_flush_mode expected 1, got %b",
                              $time, in_flush_mode));
      next_cycle();
      flush_l1i_req = 1'b0;
      while (flush_done !== 1'b1)
         next_cycle();
      assert (in_flush_mode === 1'b0)
      else fail_run($sformatf("mismatch at %0t: in_flush_mode expected 0, got %b",
                              $time, in_flush_mode));
      assert (expected_wb.size() == 0)
      else fail_run($sformatf("%0d expected memory writebacks never arrived", expected_wb.size()));
      next_cycle();
      assert (flush_done === 1'b0 && done_count == done_before + 1)
      else fail_run("flush_done did not pulse exactly once");
      for (int i = 0; i < L2_LINES; i++)
      begin
         l2_valid[i] = 1'b0;
         l2_dirty[i] = 1'b0;
      end
      for (int i = 0; i < L1_LINES; i++)
      begin
         if (req_l1d)
         begin
            l1d_valid[i] = 1'b0;
            l1d_dirty[i] = 1'b0;
         end
         if (req_l1i)
            l1i_valid[i] = 1'b0;
      end
      check_all_lines();
   endtask

   // writeback and done monitor
   always @(negedge clk)
   begin
      if (!reset && flush_done === 1'b1)
         done_count++;
      if (!reset && mem_wb_valid === 1'b1)
      begin
         assert (expected_wb.size() > 0)
         else fail_run($sformatf("memory writeback of line %0d at %0t was not expected",
                                 mem_wb_index, $time));
         next_index = expected_wb.pop_front();
         assert (mem_wb_index == next_index)
         else fail_run($sformatf("mismatch at %0t: mem_wb_index expected %0d, got %0d",
                                 $time, next_index, mem_wb_index));
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      assert (cycle_count < MAX_CYCLES)
      else fail_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
      assert (DUT.flush_checks.failures == 0)
      else fail_run("a concurrent assertion on the flush sequencer failed");
   end

   initial
   begin
      int touches;
      logic [1:0] combo;
      void'($urandom(32'h23d0));
      reset = 1'b1;
      touch_valid = 1'b0;
      touch_sel = flush_ctl_pkg::SEL_L1D;
      touch_index = '0;
      touch_dirty = 1'b0;
      flush_l1d_req = 1'b0;
      flush_l1i_req = 1'b0;
      probe_sel = flush_ctl_pkg::SEL_L1D;
      probe_index = '0;
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;

      assert (in_flush_mode === 1'b0 && flush_done === 1'b0 && mem_wb_valid === 1'b0)
      else fail_run("flush outputs not idle after reset");
      check_all_lines();

      // l1d only
      touch_line(flush_ctl_pkg::SEL_L1D, 3, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L1D, 7, 1'b0);
      touch_line(flush_ctl_pkg::SEL_L1D, 12, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L1D, 20, 1'b1); // lands on l1d line 4
      touch_line(flush_ctl_pkg::SEL_L2, 5, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L2, 19, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L2, 7, 1'b0);
      touch_line(flush_ctl_pkg::SEL_L2, 28, 1'b0);
      touch_line(flush_ctl_pkg::SEL_L1I, 2, 1'b0);
      touch_line(flush_ctl_pkg::SEL_L1I, 9, 1'b1);
      run_flush(1'b1, 1'b0, 1'b0);

      // l1i only
      touch_line(flush_ctl_pkg::SEL_L1D, 1, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L1D, 6, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L2, 30, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L2, 2, 1'b0);
      touch_line(flush_ctl_pkg::SEL_L1I, 4, 1'b0);
      run_flush(1'b0, 1'b1, 1'b0);

      // both in one cycle
      touch_line(flush_ctl_pkg::SEL_L2, 0, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L1I, 15, 1'b0);
      touch_line(flush_ctl_pkg::SEL_L1D, 15, 1'b1);
      run_flush(1'b1, 1'b1, 1'b0);

      // l1i request one cycle late
      touch_line(flush_ctl_pkg::SEL_L1D, 9, 1'b1);
      touch_line(flush_ctl_pkg::SEL_L1I, 3, 1'b0);
      touch_line(flush_ctl_pkg::SEL_L2, 16, 1'b1);
      run_flush(1'b1, 1'b0, 1'b1);

      run_flush(1'b1, 1'b1, 1'b0); // nothing left to write back

      for (int round = 0; round < 20; round++)
      begin
         touches = $urandom_range(1, 12);
         for (int t = 0; t < touches; t++)
         begin
            touch_line(flush_ctl_pkg::cache_sel_t'($urandom_range(0, 2)),
                       $urandom_range(0, L2_LINES - 1), $urandom_range(0, 1));
         end
         combo = $urandom_range(1, 3);
         run_flush(combo[0], combo[1], 1'b0);
      end

      if (DUT.flush_checks.failures == 0)
      begin
         $display("Verification passed");
         $finish;
      end
      else
      begin
         fail_run($sformatf("%0d concurrent assertion failures", DUT.flush_checks.failures));
      end
   end

endmodule

// ==== list.f ====
+incdir+common
common/cache_line_pkg.sv
common/flush_ctl_pkg.sv
common/sweep_if.sv
src/flush_sequencer.sv
src/line_sweep_counter.sv
cache/line_state_array.sv
cache/cache_flush_unit.sv
src/cache_flush_top.sv
verification/cache_flush_assertions.sv
verification/cache_flush_tb.sv
